// ==== compile.f ====
rtl/vlsu_pkg.sv
rtl/vlsu_regs.sv
rtl/vlsu_seq.sv
rtl/vlsu_rob.sv
rtl/vlsu_align.sv
rtl/vlsu_top.sv
tests/tb_vlsu.sv

// ==== rtl/vlsu_align.sv ====
// Byte-lane rotation between memory and register file words, plus the VRF byte enables
`timescale 1ns/1ns

module vlsu_align (
  input  logic                               is_load_i,
  input  logic [1:0]                         vsew_i,
  input  logic [$clog2(vlsu_pkg::elenb)-1:0] mem_byte_off_i,
  input  logic [$clog2(vlsu_pkg::elenb)-1:0] vrf_byte_off_i,
  input  logic [vlsu_pkg::elen-1:0]          rob_data_i,
  output logic [vlsu_pkg::elen-1:0]          mem_rdata_o,
  input  logic [vlsu_pkg::elen-1:0]          vrf_rdata_i,
  output logic [vlsu_pkg::elen-1:0]          store_data_o,
  output logic [vlsu_pkg::elen-1:0]          load_data_o,
  output logic [vlsu_pkg::elenb-1:0]         vrf_wbe_o
);
  import vlsu_pkg::*;

  localparam int off_w = $clog2(elenb);

  // Move byte lane off down to lane 0
  function automatic logic [elen-1:0] rot_down(input logic [elen-1:0] word,
                                               input logic [off_w-1:0] off);
    logic [2*elen-1:0] dbl;
    dbl = {word, word} >> {off, 3'b000};
    return dbl[elen-1:0];
  endfunction

  // Move lane 0 up to byte lane off
  function automatic logic [elen-1:0] rot_up(input logic [elen-1:0] word,
                                             input logic [off_w-1:0] off);
    logic [off_w-1:0] back;
    back = off_w'(elenb) - off;
    return rot_down(word, back);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Load path, memory lanes to VRF lanes
  //////////////////////////////////////////////////////////////////////

  assign load_data_o = rot_up(rot_down(rob_data_i, mem_byte_off_i), vrf_byte_off_i);

  // Only the element bytes are written, the rest of the VRF word is kept
  assign vrf_wbe_o = is_load_i ? elenb'(ew_mask(vsew_i) << vrf_byte_off_i) : '0;

  //////////////////////////////////////////////////////////////////////
  // Store path, VRF lanes to memory lanes
  //////////////////////////////////////////////////////////////////////

  // Element goes into the buffer in lane 0
  assign store_data_o = rot_down(vrf_rdata_i, vrf_byte_off_i);

  // Buffer head placed on the lanes of its memory request
  assign mem_rdata_o = rot_up(rob_data_i, mem_byte_off_i);

endmodule

// ==== rtl/vlsu_pkg.sv ====
// Shared widths, register map and element-width codes used by every block of the load/store unit
package vlsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data path and vector register file geometry
  //////////////////////////////////////////////////////////////////////

  localparam int addr_w     = 32;
  localparam int elen       = 32;
  localparam int elenb      = elen / 8;
  localparam int vlen_bytes = 32;
  localparam int vrf_words  = vlen_bytes / elenb;
  localparam int vrf_addr_w = 8;
  // Register number field, 32 registers of vrf_words words each
  localparam int vd_w       = vrf_addr_w - $clog2(vrf_words);
  localparam int vl_w       = 6;

  // Element width codes
  localparam logic [1:0] ew_8  = 2'd0;
  localparam logic [1:0] ew_16 = 2'd1;
  localparam logic [1:0] ew_32 = 2'd2;

  //////////////////////////////////////////////////////////////////////
  // Register map and command word
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] reg_base   = 2'd0;
  localparam logic [1:0] reg_stride = 2'd1;
  localparam logic [1:0] reg_cmd    = 2'd2;
  localparam logic [1:0] reg_status = 2'd3;

  localparam int cmd_vl_lsb      = 0;
  localparam int cmd_vsew_lsb    = 6;
  localparam int cmd_vd_lsb      = 8;
  localparam int cmd_load_bit    = 16;
  localparam int cmd_strided_bit = 17;

  // Byte mask of one element sitting in lane 0
  function automatic logic [elenb-1:0] ew_mask(input logic [1:0] vsew);
    case (vsew)
      ew_8:    return 4'b0001;
      ew_16:   return 4'b0011;
      ew_32:   return 4'b1111;
      default: return 4'b1111;
    endcase
  endfunction

endpackage

// ==== rtl/vlsu_regs.sv ====
// Wishbone classic register block that takes base, stride and command from software and reports status
`timescale 1ns/1ns

module vlsu_regs (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // Wishbone classic slave
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [1:0]                      wb_adr_i,
  input  logic [31:0]                     wb_dat_i,
  output logic [31:0]                     wb_dat_o,
  output logic                            wb_ack_o,
  // Sequencer status
  input  logic                            busy_i,
  input  logic                            finish_i,
  // Command to the sequencer
  output logic [vlsu_pkg::addr_w-1:0]     base_o,
  output logic [vlsu_pkg::addr_w-1:0]     stride_o,
  output logic [vlsu_pkg::vl_w-1:0]       vl_o,
  output logic [1:0]                      vsew_o,
  output logic [vlsu_pkg::vd_w-1:0]       vd_o,
  output logic                            is_load_o,
  output logic                            strided_o,
  output logic                            start_o
);
  import vlsu_pkg::*;

  logic                ack_q;
  logic                done_q;
  logic [addr_w-1:0]   base_q;
  logic [addr_w-1:0]   stride_q;
  logic [31:0]         cmd_q;
  logic                access;
  logic                status_read;
  logic [31:0]         rdata;

  // A new access is seen once, the cycle before its acknowledge
  assign access      = wb_cyc_i & wb_stb_i & ~ack_q;
  assign status_read = access & ~wb_we_i & (wb_adr_i == reg_status);
  // Command writes are dropped while a vector is in flight
  assign start_o     = access & wb_we_i & (wb_adr_i == reg_cmd) & ~busy_i;

  always_comb begin
    case (wb_adr_i)
      reg_base:   rdata = base_q;
      reg_stride: rdata = stride_q;
      reg_cmd:    rdata = cmd_q;
      default:    rdata = {30'd0, done_q, busy_i};
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q  <= 1'b0;
      done_q <= 1'b0;
      cmd_q  <= '0;
    end else begin
      ack_q <= access;
      if (start_o) begin
        cmd_q <= wb_dat_i;
      end
      // A finish in the same cycle as a status read keeps done set
      if (finish_i) begin
        done_q <= 1'b1;
      end else if (status_read) begin
        done_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access & wb_we_i & (wb_adr_i == reg_base)) begin
      base_q <= wb_dat_i;
    end
    if (access & wb_we_i & (wb_adr_i == reg_stride)) begin
      stride_q <= wb_dat_i;
    end
    if (access & ~wb_we_i) begin
      wb_dat_o <= rdata;
    end
  end

  assign wb_ack_o  = ack_q;
  assign base_o    = base_q;
  assign stride_o  = stride_q;
  assign vl_o      = cmd_q[cmd_vl_lsb +: vl_w];
  assign vsew_o    = cmd_q[cmd_vsew_lsb +: 2];
  assign vd_o      = cmd_q[cmd_vd_lsb +: vd_w];
  assign is_load_o = cmd_q[cmd_load_bit];
  assign strided_o = cmd_q[cmd_strided_bit];

endmodule

// ==== rtl/vlsu_rob.sv ====
// Reorder buffer that hands out ids, takes entries back by id and releases them in issue order
`timescale 1ns/1ns

module vlsu_rob #(
  parameter  int nr_outstanding = 8,
  localparam int id_w           = $clog2(nr_outstanding)
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Allocation
  input  logic                      alloc_i,
  output logic [id_w-1:0]           id_o,
  output logic                      full_o,
  // Fill by id
  input  logic                      push_i,
  input  logic [id_w-1:0]           push_id_i,
  input  logic [vlsu_pkg::elen-1:0] push_data_i,
  // In-order head
  output logic                      head_valid_o,
  output logic [id_w-1:0]           head_id_o,
  output logic [vlsu_pkg::elen-1:0] head_data_o,
  input  logic                      pop_i
);
  import vlsu_pkg::*;

  // Pointers carry one wrap bit to tell full from empty
  logic [id_w:0]             wptr_q;
  logic [id_w:0]             rptr_q;
  logic [nr_outstanding-1:0] valid_q;
  logic [elen-1:0]           data_q [nr_outstanding];

  assign id_o      = wptr_q[id_w-1:0];
  assign head_id_o = rptr_q[id_w-1:0];
  assign full_o    = (wptr_q[id_w] != rptr_q[id_w])
                     && (wptr_q[id_w-1:0] == rptr_q[id_w-1:0]);

  // No fall-through, a pushed entry reaches the head one cycle later
  assign head_valid_o = valid_q[head_id_o];
  assign head_data_o  = data_q[head_id_o];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      valid_q <= '0;
    end else begin
      if (alloc_i) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop_i) begin
        rptr_q             <= rptr_q + 1'b1;
        valid_q[head_id_o] <= 1'b0;
      end
      if (push_i) begin
        valid_q[push_id_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[push_id_i] <= push_data_i;
    end
  end

endmodule

// ==== rtl/vlsu_seq.sv ====
// Element sequencer that walks a vector on the memory side and the register file side
`timescale 1ns/1ns

module vlsu_seq (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 start_i,
  input  logic [vlsu_pkg::addr_w-1:0]          base_i,
  input  logic [vlsu_pkg::addr_w-1:0]          stride_i,
  input  logic [vlsu_pkg::vl_w-1:0]            vl_i,
  input  logic [1:0]                           vsew_i,
  input  logic [vlsu_pkg::vd_w-1:0]            vd_i,
  input  logic                                 is_load_i,
  input  logic                                 strided_i,
  output logic                                 busy_o,
  output logic                                 finish_o,
  // Memory request side
  output logic                                 mem_req_valid_o,
  input  logic                                 mem_req_ready_i,
  output logic [vlsu_pkg::addr_w-1:0]          mem_req_addr_o,
  output logic [$clog2(vlsu_pkg::elenb)-1:0]   mem_byte_off_o,
  output logic [vlsu_pkg::elenb-1:0]           mem_req_strb_o,
  // Register file side
  output logic [vlsu_pkg::vrf_addr_w-1:0]      vrf_addr_o,
  output logic [$clog2(vlsu_pkg::elenb)-1:0]   vrf_byte_off_o,
  output logic                                 vrf_re_o,
  input  logic                                 vrf_rvalid_i,
  output logic                                 vrf_we_o,
  input  logic                                 vrf_wvalid_i,
  // Reorder buffer control
  input  logic                                 rob_full_i,
  input  logic                                 rob_head_valid_i,
  output logic                                 rob_alloc_o,
  output logic                                 rob_pop_o
);
  import vlsu_pkg::*;

  // Byte counters reach vl times four at most
  localparam int cnt_w = vl_w + 2;
  localparam int off_w = $clog2(elenb);

  logic              busy_q;
  logic [cnt_w-1:0]  mem_cnt_q;
  logic [cnt_w-1:0]  vrf_cnt_q;
  logic [cnt_w-1:0]  total_bytes;
  logic [cnt_w-1:0]  esize;
  logic              mem_done;
  logic              vrf_done;
  logic              mem_fire;
  logic              vrf_fire;
  logic [addr_w-1:0] mem_addr;
  logic [addr_w-1:0] align_addr;

  // Byte address of the element whose VRF byte position is cnt
  function automatic logic [addr_w-1:0] elem_addr(input logic [cnt_w-1:0] cnt);
    logic [cnt_w-1:0] idx;
    idx = cnt >> vsew_i;
    if (strided_i) begin
      return base_i + addr_w'(idx) * stride_i;
    end
    return base_i + addr_w'(cnt);
  endfunction

  assign esize       = cnt_w'(1) << vsew_i;
  assign total_bytes = cnt_w'(vl_i) << vsew_i;
  assign mem_done    = mem_cnt_q == total_bytes;
  assign vrf_done    = vrf_cnt_q == total_bytes;

  // Loads align at the VRF write, stores align each side at its own counter
  always_comb begin
    mem_addr   = elem_addr(mem_cnt_q);
    align_addr = elem_addr(is_load_i ? vrf_cnt_q : mem_cnt_q);
  end

  //////////////////////////////////////////////////////////////////////
  // Advance conditions
  //////////////////////////////////////////////////////////////////////

  // Loads need a free id, stores need the next element in the buffer head
  assign mem_req_valid_o = busy_q & ~mem_done & (is_load_i ? ~rob_full_i : rob_head_valid_i);
  assign mem_fire        = mem_req_valid_o & mem_req_ready_i;

  assign vrf_we_o = busy_q & is_load_i & ~vrf_done & rob_head_valid_i;
  assign vrf_re_o = busy_q & ~is_load_i & ~vrf_done & ~rob_full_i;
  assign vrf_fire = (vrf_we_o & vrf_wvalid_i) | (vrf_re_o & vrf_rvalid_i);

  assign rob_alloc_o = is_load_i ? mem_fire : (vrf_re_o & vrf_rvalid_i);
  assign rob_pop_o   = is_load_i ? (vrf_we_o & vrf_wvalid_i) : mem_fire;

  assign finish_o = busy_q & mem_done & vrf_done;
  assign busy_o   = busy_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      mem_cnt_q <= '0;
      vrf_cnt_q <= '0;
    end else if (start_i) begin
      busy_q    <= 1'b1;
      mem_cnt_q <= '0;
      vrf_cnt_q <= '0;
    end else begin
      if (finish_o) begin
        busy_q <= 1'b0;
      end
      if (mem_fire) begin
        mem_cnt_q <= mem_cnt_q + esize;
      end
      if (vrf_fire) begin
        vrf_cnt_q <= vrf_cnt_q + esize;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Addresses and strobes
  //////////////////////////////////////////////////////////////////////

  // An element is expected to fit inside one memory word
  assign mem_req_addr_o = {mem_addr[addr_w-1:off_w], {off_w{1'b0}}};
  assign mem_req_strb_o = elenb'(ew_mask(vsew_i) << mem_addr[off_w-1:0]);
  assign mem_byte_off_o = align_addr[off_w-1:0];

  assign vrf_addr_o     = {vd_i, {$clog2(vrf_words){1'b0}}}
                          + vrf_addr_w'(vrf_cnt_q[cnt_w-1:off_w]);
  assign vrf_byte_off_o = vrf_cnt_q[off_w-1:0];

endmodule

// ==== rtl/vlsu_top.sv ====
// Top level of the vector load/store unit, connecting register block, sequencer, buffer and aligner
`timescale 1ns/1ns

module vlsu_top #(
  parameter  int nr_outstanding = 8,
  localparam int id_w           = $clog2(nr_outstanding)
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // Wishbone classic slave
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [1:0]                      wb_adr_i,
  input  logic [31:0]                     wb_dat_i,
  output logic [31:0]                     wb_dat_o,
  output logic                            wb_ack_o,
  // Memory request
  output logic                            mem_req_valid_o,
  input  logic                            mem_req_ready_i,
  output logic [vlsu_pkg::addr_w-1:0]     mem_req_addr_o,
  output logic                            mem_req_we_o,
  output logic [vlsu_pkg::elenb-1:0]      mem_req_strb_o,
  output logic [vlsu_pkg::elen-1:0]       mem_req_wdata_o,
  output logic [id_w-1:0]                 mem_req_id_o,
  // Memory result
  input  logic                            mem_rsp_valid_i,
  input  logic [id_w-1:0]                 mem_rsp_id_i,
  input  logic [vlsu_pkg::elen-1:0]       mem_rsp_rdata_i,
  // Vector register file
  output logic [vlsu_pkg::vrf_addr_w-1:0] vrf_raddr_o,
  output logic                            vrf_re_o,
  input  logic [vlsu_pkg::elen-1:0]       vrf_rdata_i,
  input  logic                            vrf_rvalid_i,
  output logic [vlsu_pkg::vrf_addr_w-1:0] vrf_waddr_o,
  output logic [vlsu_pkg::elen-1:0]       vrf_wdata_o,
  output logic [vlsu_pkg::elenb-1:0]      vrf_wbe_o,
  output logic                            vrf_we_o,
  input  logic                            vrf_wvalid_i
);
  import vlsu_pkg::*;

  logic [addr_w-1:0]     base;
  logic [addr_w-1:0]     stride;
  logic [vl_w-1:0]       vl;
  logic [1:0]            vsew;
  logic [vd_w-1:0]       vd;
  logic                  is_load;
  logic                  strided;
  logic                  start;
  logic                  busy;
  logic                  finish;
  logic [$clog2(elenb)-1:0] mem_byte_off;
  logic [$clog2(elenb)-1:0] vrf_byte_off;
  logic [vrf_addr_w-1:0] vrf_addr;
  logic                  rob_full;
  logic                  rob_alloc;
  logic                  rob_pop;
  logic [id_w-1:0]       rob_id;
  logic                  rob_push;
  logic [id_w-1:0]       rob_push_id;
  logic [elen-1:0]       rob_push_data;
  logic                  rob_head_valid;
  logic [id_w-1:0]       rob_head_id;
  logic [elen-1:0]       rob_head_data;
  logic [elen-1:0]       store_elem;

  vlsu_regs u_regs (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .busy_i    (busy),
    .finish_i  (finish),
    .base_o    (base),
    .stride_o  (stride),
    .vl_o      (vl),
    .vsew_o    (vsew),
    .vd_o      (vd),
    .is_load_o (is_load),
    .strided_o (strided),
    .start_o   (start)
  );

  vlsu_seq u_seq (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .start_i          (start),
    .base_i           (base),
    .stride_i         (stride),
    .vl_i             (vl),
    .vsew_i           (vsew),
    .vd_i             (vd),
    .is_load_i        (is_load),
    .strided_i        (strided),
    .busy_o           (busy),
    .finish_o         (finish),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_byte_off_o   (mem_byte_off),
    .mem_req_strb_o   (mem_req_strb_o),
    .vrf_addr_o       (vrf_addr),
    .vrf_byte_off_o   (vrf_byte_off),
    .vrf_re_o         (vrf_re_o),
    .vrf_rvalid_i     (vrf_rvalid_i),
    .vrf_we_o         (vrf_we_o),
    .vrf_wvalid_i     (vrf_wvalid_i),
    .rob_full_i       (rob_full),
    .rob_head_valid_i (rob_head_valid),
    .rob_alloc_o      (rob_alloc),
    .rob_pop_o        (rob_pop)
  );

  // Loads fill the buffer from memory results, stores from VRF reads
  assign rob_push      = is_load ? mem_rsp_valid_i : rob_alloc;
  assign rob_push_id   = is_load ? mem_rsp_id_i : rob_id;
  assign rob_push_data = is_load ? mem_rsp_rdata_i : store_elem;

  vlsu_rob #(
    .nr_outstanding (nr_outstanding)
  ) u_rob (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .alloc_i      (rob_alloc),
    .id_o         (rob_id),
    .full_o       (rob_full),
    .push_i       (rob_push),
    .push_id_i    (rob_push_id),
    .push_data_i  (rob_push_data),
    .head_valid_o (rob_head_valid),
    .head_id_o    (rob_head_id),
    .head_data_o  (rob_head_data),
    .pop_i        (rob_pop)
  );

  vlsu_align u_align (
    .is_load_i      (is_load),
    .vsew_i         (vsew),
    .mem_byte_off_i (mem_byte_off),
    .vrf_byte_off_i (vrf_byte_off),
    .rob_data_i     (rob_head_data),
    .mem_rdata_o    (mem_req_wdata_o),
    .vrf_rdata_i    (vrf_rdata_i),
    .store_data_o   (store_elem),
    .load_data_o    (vrf_wdata_o),
    .vrf_wbe_o      (vrf_wbe_o)
  );

  // Stores carry the id of the buffer head they drain
  assign mem_req_id_o = is_load ? rob_id : rob_head_id;
  assign mem_req_we_o = ~is_load;
  assign vrf_raddr_o  = vrf_addr;
  assign vrf_waddr_o  = vrf_addr;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message in the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_vlsu -f compile.f; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_vlsu > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tests/tb_vlsu.sv ====
// Directed testbench for the vector load/store unit, compiled as the simulation top with its models
`timescale 1ns/1ns

module tb_vlsu;
  import vlsu_pkg::*;

  localparam int nr_out      = 8;
  localparam int id_bits     = $clog2(nr_out);
  localparam int mem_size    = 1024;
  localparam int vrf_size    = 256;
  localparam int total_elems = 8 + 12 + 13 + 16;
  // Reset, a fixed cost per test and a generous bound per element
  localparam int wd_cycles   = 16 + 5 * 400 + total_elems * 100;

  logic                  clk_i;
  logic                  rst_i;
  logic                  wb_cyc_i;
  logic                  wb_stb_i;
  logic                  wb_we_i;
  logic [1:0]            wb_adr_i;
  logic [31:0]           wb_dat_i;
  logic [31:0]           wb_dat_o;
  logic                  wb_ack_o;
  logic                  mem_req_valid_o;
  logic                  mem_req_ready_i;
  logic [addr_w-1:0]     mem_req_addr_o;
  logic                  mem_req_we_o;
  logic [elenb-1:0]      mem_req_strb_o;
  logic [elen-1:0]       mem_req_wdata_o;
  logic [id_bits-1:0]    mem_req_id_o;
  logic                  mem_rsp_valid_i;
  logic [id_bits-1:0]    mem_rsp_id_i;
  logic [elen-1:0]       mem_rsp_rdata_i;
  logic [vrf_addr_w-1:0] vrf_raddr_o;
  logic                  vrf_re_o;
  logic [elen-1:0]       vrf_rdata_i;
  logic                  vrf_rvalid_i;
  logic [vrf_addr_w-1:0] vrf_waddr_o;
  logic [elen-1:0]       vrf_wdata_o;
  logic [elenb-1:0]      vrf_wbe_o;
  logic                  vrf_we_o;
  logic                  vrf_wvalid_i;

  // Models and expected images
  logic [7:0]         mem_bytes [0:mem_size-1];
  logic [7:0]         exp_mem   [0:mem_size-1];
  logic [31:0]        vrf_mem   [0:vrf_size-1];
  logic [31:0]        exp_vrf   [0:vrf_size-1];
  logic [id_bits-1:0] pend_id   [$];
  logic [31:0]        pend_data [$];
  int                 pend_due  [$];
  int                 cycle_cnt;
  int                 traffic_cycles;
  logic [31:0]        rng_state = 32'h15f5_09dc;

  vlsu_top #(
    .nr_outstanding (nr_out)
  ) u_dut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_strb_o  (mem_req_strb_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_req_id_o    (mem_req_id_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_id_i    (mem_rsp_id_i),
    .mem_rsp_rdata_i (mem_rsp_rdata_i),
    .vrf_raddr_o     (vrf_raddr_o),
    .vrf_re_o        (vrf_re_o),
    .vrf_rdata_i     (vrf_rdata_i),
    .vrf_rvalid_i    (vrf_rvalid_i),
    .vrf_waddr_o     (vrf_waddr_o),
    .vrf_wdata_o     (vrf_wdata_o),
    .vrf_wbe_o       (vrf_wbe_o),
    .vrf_we_o        (vrf_we_o),
    .vrf_wvalid_i    (vrf_wvalid_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // LCG step, upper bits only
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state >> 8;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory and VRF models
  //////////////////////////////////////////////////////////////////////

  // Inputs change on the falling edge, handshakes are taken just before the rising edge
  always @(negedge clk_i) begin : bus_models
    int         n;
    int         sel;
    int         start;
    logic       found;
    logic [9:0] a;
    cycle_cnt       = cycle_cnt + 1;
    mem_req_ready_i = (next_rand() % 4) != 0;
    mem_rsp_valid_i = 1'b0;
    n     = pend_id.size();
    found = 1'b0;
    sel   = 0;
    if (n > 0) begin
      start = int'(next_rand() % 32'(n));
      for (int k = 0; k < n; k++) begin
        if (!found && pend_due[(start + k) % n] <= cycle_cnt) begin
          found = 1'b1;
          sel   = (start + k) % n;
        end
      end
    end
    if (found) begin
      mem_rsp_valid_i = 1'b1;
      mem_rsp_id_i    = pend_id[sel];
      mem_rsp_rdata_i = pend_data[sel];
      pend_id.delete(sel);
      pend_data.delete(sel);
      pend_due.delete(sel);
    end
    #1;
    vrf_rdata_i = vrf_mem[vrf_raddr_o];
    #1;
    a = mem_req_addr_o[9:0];
    if (mem_req_valid_o && mem_req_ready_i) begin
      if (mem_req_we_o) begin
        for (int b = 0; b < elenb; b++) begin
          if (mem_req_strb_o[b]) begin
            mem_bytes[a + b] = mem_req_wdata_o[8 * b +: 8];
          end
        end
      end else begin
        pend_id.push_back(mem_req_id_o);
        pend_data.push_back({mem_bytes[a + 3], mem_bytes[a + 2], mem_bytes[a + 1], mem_bytes[a]});
        pend_due.push_back(cycle_cnt + 1 + int'(next_rand() % 6));
      end
    end
    if (vrf_we_o && vrf_wvalid_i) begin
      for (int b = 0; b < elenb; b++) begin
        if (vrf_wbe_o[b]) begin
          vrf_mem[vrf_waddr_o][8 * b +: 8] = vrf_wdata_o[8 * b +: 8];
        end
      end
    end
    if (mem_req_valid_o || vrf_re_o || vrf_we_o) begin
      traffic_cycles = traffic_cycles + 1;
    end
  end

  initial begin
    repeat (wd_cycles) @(posedge clk_i);
    stop_run($sformatf("Timeout: the tests did not finish within %0d cycles", wd_cycles));
  end

  //////////////////////////////////////////////////////////////////////
  // Bus tasks and helpers
  //////////////////////////////////////////////////////////////////////

  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdat);
    int waited;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    waited   = 0;
    do begin
      @(negedge clk_i);
      waited = waited + 1;
      if (waited > 8) begin
        stop_run("Wishbone access was never acknowledged");
      end
    end while (!wb_ack_o);
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 32'd0, dat);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while (st[1] == 1'b0) begin
      if (polls == 500) begin
        stop_run("Command did not report done within 500 status polls");
      end
      wb_read(reg_status, st);
      polls = polls + 1;
    end
    check_value(st, 32'h2, "status when done is first seen");
  endtask

  task automatic run_cmd(input logic [31:0] cmd);
    wb_write(reg_cmd, cmd);
    wait_done();
  endtask

  function automatic logic [31:0] make_cmd(input int vl, input logic [1:0] vsew, input int vd,
                                           input logic load, input logic strided);
    logic [31:0] c;
    c = '0;
    c[cmd_vl_lsb +: vl_w] = vl_w'(vl);
    c[cmd_vsew_lsb +: 2]  = vsew;
    c[cmd_vd_lsb +: 5]    = 5'(vd);
    c[cmd_load_bit]       = load;
    c[cmd_strided_bit]    = strided;
    return c;
  endfunction

  function automatic logic [7:0] vrf_byte(input int vd, input int pos);
    logic [31:0] w;
    w = vrf_mem[vd * vrf_words + pos / elenb];
    return w[8 * (pos % elenb) +: 8];
  endfunction

  task automatic set_exp_byte(input int vd, input int pos, input logic [7:0] val);
    exp_vrf[vd * vrf_words + pos / elenb][8 * (pos % elenb) +: 8] = val;
  endtask

  task automatic take_snapshot();
    for (int a = 0; a < mem_size; a++) exp_mem[a] = mem_bytes[a];
    for (int w = 0; w < vrf_size; w++) exp_vrf[w] = vrf_mem[w];
  endtask

  task automatic compare_models(input string what);
    for (int a = 0; a < mem_size; a++) begin
      check_value({24'd0, mem_bytes[a]}, {24'd0, exp_mem[a]},
                  $sformatf("%s, memory byte %0h", what, a));
    end
    for (int w = 0; w < vrf_size; w++) begin
      check_value(vrf_mem[w], exp_vrf[w], $sformatf("%s, VRF word %0d", what, w));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reg_readback();
    logic [31:0] v;
    wb_read(reg_status, v);
    check_value(v, 32'h0, "status after reset");
    wb_write(reg_base, 32'h0000_0124);
    wb_write(reg_stride, 32'h0000_0014);
    wb_read(reg_base, v);
    check_value(v, 32'h0000_0124, "base readback");
    wb_read(reg_stride, v);
    check_value(v, 32'h0000_0014, "stride readback");
  endtask

  task automatic test_load_unit32();
    take_snapshot();
    for (int p = 0; p < 8 * 4; p++) set_exp_byte(3, p, mem_bytes['h40 + p]);
    wb_write(reg_base, 32'h40);
    run_cmd(make_cmd(8, ew_32, 3, 1'b1, 1'b0));
    compare_models("32-bit unit-stride load");
  endtask

  task automatic test_store_strided16();
    take_snapshot();
    for (int i = 0; i < 12; i++) begin
      for (int b = 0; b < 2; b++) exp_mem['h200 + 6 * i + b] = vrf_byte(5, 2 * i + b);
    end
    wb_write(reg_base, 32'h200);
    wb_write(reg_stride, 32'd6);
    run_cmd(make_cmd(12, ew_16, 5, 1'b0, 1'b1));
    compare_models("16-bit strided store");
  endtask

  task automatic test_load_unaligned8();
    take_snapshot();
    for (int i = 0; i < 13; i++) set_exp_byte(7, i, mem_bytes['hf3 + i]);
    wb_write(reg_base, 32'hf3);
    run_cmd(make_cmd(13, ew_8, 7, 1'b1, 1'b0));
    compare_models("8-bit unaligned load");
  endtask

  task automatic test_zero_vl_and_busy();
    logic [31:0] v;
    logic [31:0] first;
    take_snapshot();
    traffic_cycles = 0;
    run_cmd(make_cmd(0, ew_32, 2, 1'b1, 1'b0));
    check_value(32'(traffic_cycles), 32'd0, "bus activity for vl of 0");
    wb_read(reg_status, v);
    check_value(v, 32'h0, "status after done was read");
    compare_models("vl of 0");
    // The store written while busy would overwrite memory at the same base
    take_snapshot();
    for (int p = 0; p < 16 * 2; p++) set_exp_byte(9, p, mem_bytes['h300 + p]);
    first = make_cmd(16, ew_16, 9, 1'b1, 1'b0);
    wb_write(reg_base, 32'h300);
    wb_write(reg_cmd, first);
    wb_write(reg_cmd, make_cmd(32, ew_8, 9, 1'b0, 1'b0));
    wait_done();
    compare_models("command written while busy");
    wb_read(reg_cmd, v);
    check_value(v, first, "command register after ignored write");
    wb_read(reg_status, v);
    check_value(v, 32'h0, "status after second read");
  endtask

  initial begin
    rst_i           = 1'b1;
    wb_cyc_i        = 1'b0;
    wb_stb_i        = 1'b0;
    wb_we_i         = 1'b0;
    wb_adr_i        = '0;
    wb_dat_i        = '0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_id_i    = '0;
    mem_rsp_rdata_i = '0;
    vrf_rdata_i     = '0;
    vrf_rvalid_i    = 1'b1;
    vrf_wvalid_i    = 1'b1;
    cycle_cnt       = 0;
    traffic_cycles  = 0;
    for (int a = 0; a < mem_size; a++) mem_bytes[a] = 8'(a ^ (a >> 3) ^ 'ha5);
    for (int w = 0; w < vrf_size; w++) begin
      vrf_mem[w] = {8'(w), 8'(w * 3 + 1), 8'(~w), 8'(w ^ 'h3c)};
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    test_reg_readback();
    test_load_unit32();
    test_store_strided16();
    test_load_unaligned8();
    test_zero_vl_and_busy();
    $display("Simulation PASSED");
    $finish;
  end

endmodule
